//--- verilog/arcade_consts.svh
`ifndef ARCADE_CONSTS_SVH
`define ARCADE_CONSTS_SVH

// ROM word address width.
// 14 bits of 16-bit words give 32 KB of program bytes.
`define ROM_AW 14

// Store depth in words.
`define ROM_WORDS (1 << `ROM_AW)

// Width of one DIP switch byte.
`define DIP_W 8

`endif

//--- verilog/arcade_pkg.sv
`include "arcade_consts.svh"

package arcade_pkg;

	// One access to the ROM store.
	typedef struct packed {
		logic               hold;   // Loader owns the store.
		logic               we;
		logic [1:0]         be;     // Byte lanes, bit 1 is the high byte.
		logic [`ROM_AW-1:0] addr;
		logic [15:0]        wdata;
	} mem_req_t;

	// One player's controls, active high.
	typedef struct packed {
		logic coin;
		logic start;
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire_a;
		logic fire_b;
	} player_in_t;

	typedef enum logic {
		mode_rallyx  = 1'b0,
		mode_jungler = 1'b1
	} game_mode_e;

	// Rally-X layout, same for both control ports.
	typedef struct packed {
		logic coin;
		logic start;
		logic up;
		logic down;
		logic right;
		logic left;
		logic fire_a;
		logic spare;
	} ctr_rallyx_t;

	typedef struct packed {
		logic coin1;
		logic coin2;
		logic right;
		logic left;
		logic fire_a;
		logic spare;
		logic fire_b;
		logic up2;
	} ctr1_jungler_t;

	typedef struct packed {
		logic start1;
		logic start2;
		logic left2;
		logic right2;
		logic fire2_a;
		logic fire2_b;
		logic down2;
		logic up1;
	} ctr2_jungler_t;

	typedef union packed {
		ctr_rallyx_t   rallyx;
		ctr1_jungler_t jungler;
	} ctr1_u;

	typedef union packed {
		ctr_rallyx_t   rallyx;
		ctr2_jungler_t jungler;
	} ctr2_u;

endpackage

//--- verilog/rom_loader.sv
`timescale 1ns/1ps
`include "arcade_consts.svh"

module rom_loader (
	input  logic                clock_24,
	input  logic                rst_n,
	input  logic                dl_active,
	input  logic                dl_wr,
	input  logic [15:0]         dl_addr,
	input  logic [7:0]          dl_data,
	output arcade_pkg::mem_req_t load_req
);

	logic dl_wr_last;
	logic wr_edge;

	// One write per rising strobe, only while downloading.
	assign wr_edge = dl_active & dl_wr & ~dl_wr_last;

	always_ff @(posedge clock_24) begin
		dl_wr_last <= dl_wr;
		if (!rst_n) begin
			load_req.hold <= 1'b0;
			load_req.we   <= 1'b0;
		end else begin
			load_req.hold <= dl_active;
			load_req.we   <= wr_edge;
		end
	end

	// Payload only moves with a strobe.
	always_ff @(posedge clock_24) begin
		if (wr_edge) begin
			load_req.addr  <= dl_addr[`ROM_AW:1];
			load_req.be    <= {dl_addr[0], ~dl_addr[0]}; // Odd bytes go high.
			load_req.wdata <= {dl_data, dl_data};
		end
	end

endmodule

//--- verilog/rom_fetch.sv
`timescale 1ns/1ps
`include "arcade_consts.svh"

module rom_fetch (
	input  logic                 clock_24,
	input  logic                 rst_n,
	input  logic [`ROM_AW:0]     cpu_rom_addr,
	input  logic                 fetch_grant,
	input  logic [15:0]          rdata,
	output arcade_pkg::mem_req_t fetch_req,
	output logic [7:0]           cpu_rom_data,
	output logic                 rom_valid
);

	logic sel_s1, sel_s2;
	logic vld_s1, vld_s2;

	// Plain word read, never holds the store.
	assign fetch_req.hold  = 1'b0;
	assign fetch_req.we    = 1'b0;
	assign fetch_req.be    = 2'b11;
	assign fetch_req.addr  = cpu_rom_addr[`ROM_AW:1];
	assign fetch_req.wdata = 16'h0000;

	always_ff @(posedge clock_24) begin
		if (!rst_n) begin
			vld_s1    <= 1'b0;
			vld_s2    <= 1'b0;
			rom_valid <= 1'b0;
		end else begin
			vld_s1    <= fetch_grant;
			vld_s2    <= vld_s1;
			rom_valid <= vld_s2;
		end
	end

	// Byte select follows its read through the pipe.
	always_ff @(posedge clock_24) begin
		sel_s1 <= cpu_rom_addr[0];
		sel_s2 <= sel_s1;
		if (vld_s2) begin
			cpu_rom_data <= sel_s2 ? rdata[15:8] : rdata[7:0];
		end
	end

endmodule

//--- verilog/rom_arbiter.sv
`timescale 1ns/1ps
`include "arcade_consts.svh"

module rom_arbiter (
	input  logic                 clock_24,
	input  logic                 rst_n,
	input  arcade_pkg::mem_req_t load_req,
	input  arcade_pkg::mem_req_t fetch_req,
	input  logic [15:0]          mem_rdata,
	output logic                 mem_en,
	output logic                 mem_we,
	output logic [1:0]           mem_be,
	output logic [`ROM_AW-1:0]   mem_addr,
	output logic [15:0]          mem_wdata,
	output logic                 fetch_grant,
	output logic [15:0]          rdata
);

	arcade_pkg::mem_req_t grant_req;
	logic                 grant_q;

	// Loader owns the store for the whole download.
	assign grant_req   = load_req.hold ? load_req : fetch_req;
	assign fetch_grant = ~load_req.hold;

	// Loader only touches memory on its write cycles.
	assign mem_en    = fetch_grant | load_req.we;
	assign mem_we    = grant_req.we;
	assign mem_be    = grant_req.be;
	assign mem_addr  = grant_req.addr;
	assign mem_wdata = grant_req.wdata;

	always_ff @(posedge clock_24) begin
		if (!rst_n) begin
			grant_q <= 1'b0;
		end else begin
			grant_q <= fetch_grant;
		end
	end

	// Read data of a granted fetch, one cycle after the store returns it.
	always_ff @(posedge clock_24) begin
		if (grant_q) begin
			rdata <= mem_rdata;
		end
	end

endmodule

//--- verilog/rom_store.sv
`timescale 1ns/1ps
`include "arcade_consts.svh"

module rom_store (
	input  logic               clock_24,
	input  logic               mem_en,
	input  logic               mem_we,
	input  logic [1:0]         mem_be,
	input  logic [`ROM_AW-1:0] mem_addr,
	input  logic [15:0]        mem_wdata,
	output logic [15:0]        mem_rdata
);

	logic [15:0] mem [`ROM_WORDS];

	always_ff @(posedge clock_24) begin
		if (mem_en) begin
			if (mem_we) begin
				if (mem_be[0]) begin
					mem[mem_addr][7:0] <= mem_wdata[7:0];
				end
				if (mem_be[1]) begin
					mem[mem_addr][15:8] <= mem_wdata[15:8];
				end
			end
			mem_rdata <= mem[mem_addr]; // Old data on a write cycle.
		end
	end

endmodule

//--- verilog/control_mapper.sv
`timescale 1ns/1ps
`include "arcade_consts.svh"

module control_mapper (
	input  logic                   clock_24,
	input  logic                   rst_n,
	input  arcade_pkg::game_mode_e game_mode,
	input  arcade_pkg::player_in_t player1,
	input  arcade_pkg::player_in_t player2,
	input  logic [2*`DIP_W-1:0]    dip_status,
	output logic [7:0]             ctr1,
	output logic [7:0]             ctr2,
	output logic [`DIP_W-1:0]      dsw1,
	output logic [`DIP_W-1:0]      dsw2
);

	arcade_pkg::ctr1_u      c1;
	arcade_pkg::ctr2_u      c2;
	logic [`DIP_W-1:0]      d1;

	always_comb begin
		d1 = ~dip_status[`DIP_W-1:0];
		if (game_mode == arcade_pkg::mode_jungler) begin
			c1.jungler.coin1   = player1.coin;
			c1.jungler.coin2   = player2.coin;
			c1.jungler.right   = player1.right;
			c1.jungler.left    = player1.left;
			c1.jungler.fire_a  = player1.fire_a;
			c1.jungler.spare   = 1'b0;
			c1.jungler.fire_b  = player1.fire_b;
			c1.jungler.up2     = player2.up;
			c2.jungler.start1  = player1.start;
			c2.jungler.start2  = player2.start;
			c2.jungler.left2   = player2.left;
			c2.jungler.right2  = player2.right;
			c2.jungler.fire2_a = player2.fire_a;
			c2.jungler.fire2_b = player2.fire_b;
			c2.jungler.down2   = player2.down;
			c2.jungler.up1     = player1.up;
			d1[`DIP_W-1]       = ~player1.down; // P1 down lives on the DIP port.
		end else begin
			c1.rallyx.coin   = player1.coin;
			c1.rallyx.start  = player1.start;
			c1.rallyx.up     = player1.up;
			c1.rallyx.down   = player1.down;
			c1.rallyx.right  = player1.right;
			c1.rallyx.left   = player1.left;
			c1.rallyx.fire_a = player1.fire_a;
			c1.rallyx.spare  = 1'b0;
			c2.rallyx.coin   = player2.coin;
			c2.rallyx.start  = player2.start;
			c2.rallyx.up     = player2.up;
			c2.rallyx.down   = player2.down;
			c2.rallyx.right  = player2.right;
			c2.rallyx.left   = player2.left;
			c2.rallyx.fire_a = player2.fire_a;
			c2.rallyx.spare  = 1'b0;
		end
	end

	// Board inputs are active low.
	always_ff @(posedge clock_24) begin
		if (!rst_n) begin
			ctr1 <= 8'hff;
			ctr2 <= 8'hff;
			dsw1 <= '1;
			dsw2 <= '1;
		end else begin
			ctr1 <= ~c1;
			ctr2 <= ~c2;
			dsw1 <= d1;
			dsw2 <= ~dip_status[2*`DIP_W-1:`DIP_W];
		end
	end

endmodule

//--- verilog/arcade_top.sv
`timescale 1ns/1ps
`include "arcade_consts.svh"

module arcade_top (
	input  logic                   clock_24,
	input  logic                   rst_n,
	input  logic                   dl_active,
	input  logic                   dl_wr,
	input  logic [15:0]            dl_addr,
	input  logic [7:0]             dl_data,
	input  logic [`ROM_AW:0]       cpu_rom_addr,
	output logic [7:0]             cpu_rom_data,
	output logic                   rom_valid,
	input  arcade_pkg::player_in_t player1,
	input  arcade_pkg::player_in_t player2,
	input  logic [2*`DIP_W-1:0]    dip_status,
	input  arcade_pkg::game_mode_e game_mode,
	output logic [7:0]             ctr1,
	output logic [7:0]             ctr2,
	output logic [`DIP_W-1:0]      dsw1,
	output logic [`DIP_W-1:0]      dsw2
);

	arcade_pkg::mem_req_t load_req;
	arcade_pkg::mem_req_t fetch_req;
	logic                 fetch_grant;
	logic [15:0]          rdata;
	logic                 mem_en;
	logic                 mem_we;
	logic [1:0]           mem_be;
	logic [`ROM_AW-1:0]   mem_addr;
	logic [15:0]          mem_wdata;
	logic [15:0]          mem_rdata;

	rom_loader i_loader (
		.clock_24  ( clock_24  ),
		.rst_n     ( rst_n     ),
		.dl_active ( dl_active ),
		.dl_wr     ( dl_wr     ),
		.dl_addr   ( dl_addr   ),
		.dl_data   ( dl_data   ),
		.load_req  ( load_req  )
	);

	rom_fetch i_fetch (
		.clock_24     ( clock_24     ),
		.rst_n        ( rst_n        ),
		.cpu_rom_addr ( cpu_rom_addr ),
		.fetch_grant  ( fetch_grant  ),
		.rdata        ( rdata        ),
		.fetch_req    ( fetch_req    ),
		.cpu_rom_data ( cpu_rom_data ),
		.rom_valid    ( rom_valid    )
	);

	rom_arbiter i_arbiter (
		.clock_24    ( clock_24    ),
		.rst_n       ( rst_n       ),
		.load_req    ( load_req    ),
		.fetch_req   ( fetch_req   ),
		.mem_rdata   ( mem_rdata   ),
		.mem_en      ( mem_en      ),
		.mem_we      ( mem_we      ),
		.mem_be      ( mem_be      ),
		.mem_addr    ( mem_addr    ),
		.mem_wdata   ( mem_wdata   ),
		.fetch_grant ( fetch_grant ),
		.rdata       ( rdata       )
	);

	rom_store i_store (
		.clock_24  ( clock_24  ),
		.mem_en    ( mem_en    ),
		.mem_we    ( mem_we    ),
		.mem_be    ( mem_be    ),
		.mem_addr  ( mem_addr  ),
		.mem_wdata ( mem_wdata ),
		.mem_rdata ( mem_rdata )
	);

	control_mapper i_mapper (
		.clock_24   ( clock_24   ),
		.rst_n      ( rst_n      ),
		.game_mode  ( game_mode  ),
		.player1    ( player1    ),
		.player2    ( player2    ),
		.dip_status ( dip_status ),
		.ctr1       ( ctr1       ),
		.ctr2       ( ctr2       ),
		.dsw1       ( dsw1       ),
		.dsw2       ( dsw2       )
	);

endmodule

//--- tests/arcade_chk.sv
`timescale 1ns/1ps

module arcade_chk (
	input logic clock_24,
	input logic rst_n,
	input logic dl_active,
	input logic mem_en,
	input logic mem_we,
	input logic fetch_grant,
	input logic rom_valid
);

	// Loader writes only while it holds the store.
	assert property (@(posedge clock_24) disable iff (!rst_n)
		!(mem_en && mem_we && fetch_grant))
		else $error("Store write in a cycle with a fetch grant");

	// Four cycles into a download no fetch result is left in the pipe.
	assert property (@(posedge clock_24) disable iff (!rst_n)
		dl_active && $past(dl_active) && $past(dl_active, 2) && $past(dl_active, 3)
			&& $past(dl_active, 4) |-> !rom_valid)
		else $error("rom_valid pulsed during download");

	// Each grant comes back three edges later.
	assert property (@(posedge clock_24) disable iff (!rst_n)
		fetch_grant |-> ##3 rom_valid)
		else $error("Granted fetch returned no rom_valid");

endmodule

//--- tests/arcade_tb.sv
`timescale 1ns/1ps
`include "arcade_consts.svh"

module arcade_tb;

	localparam int N_BYTES = 512;
	localparam int MAX_GAP = 3;
	localparam int N_FETCH = 400;
	localparam int N_MAP   = 200;
	// Reset, download at worst-case gaps, fetch and two mapper runs, plus slack.
	localparam int CYCLE_LIMIT = 16 + N_BYTES * (MAX_GAP + 2) + N_FETCH + 2 * N_MAP + 100;

	logic                   clock_24;
	logic                   rst_n;
	logic                   dl_active;
	logic                   dl_wr;
	logic [15:0]            dl_addr;
	logic [7:0]             dl_data;
	logic [`ROM_AW:0]       cpu_rom_addr;
	logic [7:0]             cpu_rom_data;
	logic                   rom_valid;
	arcade_pkg::player_in_t player1;
	arcade_pkg::player_in_t player2;
	logic [2*`DIP_W-1:0]    dip_status;
	arcade_pkg::game_mode_e game_mode;
	logic [7:0]             ctr1;
	logic [7:0]             ctr2;
	logic [`DIP_W-1:0]      dsw1;
	logic [`DIP_W-1:0]      dsw2;

	integer           seed;
	logic [7:0]       rom_model [N_BYTES];
	int               cycles = 0;
	int               fetch_count = 0;
	logic             fetch_on;
	logic [`ROM_AW:0] a1, a2, a3; // CPU address history, one per cycle.
	logic             v1 = 1'b0;
	logic             v2 = 1'b0;
	logic             v3 = 1'b0;
	logic [31:0]      map_exp;
	logic             map_live = 1'b0;

	arcade_top i_dut (.*);

	bind arcade_top arcade_chk i_chk (
		.clock_24    ( clock_24    ),
		.rst_n       ( rst_n       ),
		.dl_active   ( dl_active   ),
		.mem_en      ( mem_en      ),
		.mem_we      ( mem_we      ),
		.fetch_grant ( fetch_grant ),
		.rom_valid   ( rom_valid   )
	);

	always #5 clock_24 = ~clock_24;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1, "Simulation stopped at first error");
	endtask

	task automatic check_equal(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		if (got !== exp) begin
			fail_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	// Active-low board bytes, packed as {ctr1, ctr2, dsw1, dsw2}.
	function automatic logic [31:0] map_ref(
		input arcade_pkg::game_mode_e mode,
		input arcade_pkg::player_in_t p1,
		input arcade_pkg::player_in_t p2,
		input logic [15:0]            dip
	);
		logic [7:0] c1;
		logic [7:0] c2;
		logic [7:0] d1;
		d1 = ~dip[7:0];
		if (mode == arcade_pkg::mode_jungler) begin
			c1 = {p1.coin, p2.coin, p1.right, p1.left, p1.fire_a, 1'b0, p1.fire_b, p2.up};
			c2 = {p1.start, p2.start, p2.left, p2.right, p2.fire_a, p2.fire_b, p2.down, p1.up};
			d1[7] = ~p1.down;
		end else begin
			c1 = {p1.coin, p1.start, p1.up, p1.down, p1.right, p1.left, p1.fire_a, 1'b0};
			c2 = {p2.coin, p2.start, p2.up, p2.down, p2.right, p2.left, p2.fire_a, 1'b0};
		end
		return {~c1, ~c2, d1, ~dip[15:8]};
	endfunction

	always @(posedge clock_24) begin
		cycles <= cycles + 1;
		if (cycles > CYCLE_LIMIT) begin
			fail_run("Timeout: the run did not finish within the cycle limit");
		end
	end

	// Fetch results come back three cycles after the address.
	always @(negedge clock_24) begin
		if (v3) begin
			check_equal("rom_valid", {15'h0000, rom_valid}, 16'h0001);
			check_equal("cpu_rom_data", {8'h00, cpu_rom_data}, {8'h00, rom_model[a3[8:0]]});
			fetch_count <= fetch_count + 1;
		end
		a3 <= a2;
		a2 <= a1;
		a1 <= cpu_rom_addr;
		v3 <= v2;
		v2 <= v1;
		v1 <= fetch_on;
	end

	always @(posedge clock_24) begin
		map_exp  <= map_ref(game_mode, player1, player2, dip_status);
		map_live <= rst_n;
	end

	always @(negedge clock_24) begin
		if (map_live) begin
			check_equal("ctr1", {8'h00, ctr1}, {8'h00, map_exp[31:24]});
			check_equal("ctr2", {8'h00, ctr2}, {8'h00, map_exp[23:16]});
			check_equal("dsw1", {8'h00, dsw1}, {8'h00, map_exp[15:8]});
			check_equal("dsw2", {8'h00, dsw2}, {8'h00, map_exp[7:0]});
		end
	end

	task automatic load_rom();
		logic [31:0] rnd;
		dl_active = 1'b1;
		for (int i = 0; i < N_BYTES; i++) begin
			rnd = $random(seed);
			rom_model[i] = rnd[7:0];
			dl_addr      = i[15:0];
			dl_data      = rnd[7:0];
			dl_wr        = 1'b1;
			cpu_rom_addr = rnd[22:8]; // Must be ignored while the loader holds.
			@(posedge clock_24);
			#1 dl_wr = 1'b0;
			repeat (int'(rnd[31:30]) + 1) begin
				@(posedge clock_24);
				#1;
			end
		end
		repeat (2) @(posedge clock_24);
		#1 dl_active = 1'b0;
		repeat (2) @(posedge clock_24);
		#1;
	endtask

	// Back to back, one new address every cycle.
	task automatic fetch_random();
		logic [31:0] rnd;
		fetch_on = 1'b1;
		for (int i = 0; i < N_FETCH; i++) begin
			rnd = $random(seed);
			cpu_rom_addr      = '0;
			cpu_rom_addr[8:0] = rnd[8:0];
			@(posedge clock_24);
			#1;
		end
		fetch_on = 1'b0;
	endtask

	task automatic map_random(input arcade_pkg::game_mode_e mode);
		logic [31:0] rnd;
		game_mode = mode;
		for (int i = 0; i < N_MAP; i++) begin
			rnd = $random(seed);
			player1    = rnd[7:0];
			player2    = rnd[15:8];
			dip_status = rnd[31:16];
			@(posedge clock_24);
			#1;
		end
	endtask

	initial begin
		seed         = 32'h1eed6450;
		clock_24     = 1'b0;
		rst_n        = 1'b0;
		dl_active    = 1'b0;
		dl_wr        = 1'b0;
		dl_addr      = '0;
		dl_data      = '0;
		cpu_rom_addr = '0;
		player1      = '0;
		player2      = '0;
		dip_status   = '0;
		game_mode    = arcade_pkg::mode_rallyx;
		fetch_on     = 1'b0;

		repeat (15) @(posedge clock_24);
		@(negedge clock_24);
		check_equal("ctr1", {8'h00, ctr1}, 16'h00ff);
		check_equal("ctr2", {8'h00, ctr2}, 16'h00ff);
		check_equal("dsw1", {8'h00, dsw1}, 16'h00ff);
		check_equal("dsw2", {8'h00, dsw2}, 16'h00ff);
		check_equal("rom_valid", {15'h0000, rom_valid}, 16'h0000);
		@(posedge clock_24);
		#1 rst_n = 1'b1;

		load_rom();
		fetch_random();
		map_random(arcade_pkg::mode_rallyx);
		map_random(arcade_pkg::mode_jungler);

		while (fetch_count < N_FETCH) begin
			@(posedge clock_24);
		end
		repeat (2) @(posedge clock_24);

		$display("Testbench passed");
		$finish;
	end

endmodule

//--- build.f
+incdir+verilog
verilog/arcade_pkg.sv
verilog/rom_loader.sv
verilog/rom_fetch.sv
verilog/rom_arbiter.sv
verilog/rom_store.sv
verilog/control_mapper.sv
verilog/arcade_top.sv
tests/arcade_chk.sv
tests/arcade_tb.sv

//--- Makefile
.PHONY: all run clean

all: run

obj_dir/Varcade_tb: build.f $(wildcard verilog/*.sv verilog/*.svh tests/*.sv)
	verilator --binary --timing --assert --top-module arcade_tb -f build.f

run: obj_dir/Varcade_tb
	obj_dir/Varcade_tb | tee sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
